//--- dv/nvme_host_port_tb.sv
`default_nettype none

module nvme_host_port_tb;
  import nvme_host_pkg::*;

  localparam int    DEPTH    = 16;
  localparam addr_t BAR0     = 64'h0000_0010_0000_0000;
  localparam logic [31:0] LFSR_SEED = 32'hf5e0be87;
  localparam logic [31:0] LFSR_MASK = 32'h80200003;  // Taps 32, 22, 2, 1

  logic     user_clk;
  logic     user_reset;
  logic     reset_req;
  logic     link_up;
  rq_beat_t rq_beat;
  logic     rq_valid;
  logic     rq_ready;
  rc_beat_t rc_beat;
  logic     rc_valid;
  logic     rc_ready;
  logic     submit;
  logic     reap;
  logic     config_done;
  logic     config_error;

  logic [31:0] lfsr;
  int          errors;

  // Core model and monitor state
  tag_t     cpl_tags[$];
  int       cpl_idx;
  int       cpl_delay;
  int       bad_cpl_idx;
  logic     rc_taken;
  logic     outstanding;   // Config write waiting for its completion
  logic     stalled;
  rq_beat_t stall_beat;
  int       beat_idx;
  rq_beat_t desc_hold;
  int       cfg_req_cnt;
  int       req_total;
  int       sent_cnt[2];   // Unwrapped doorbell value per queue
  int       strobe_cnt[2];
  dword_t   last_val[2];

  tb_clock_gen #(.PERIOD(20)) i_clock_gen (
    .reset_req  (reset_req),
    .user_clk   (user_clk),
    .user_reset (user_reset)
  );

  nvme_host_port i_dut (
    .user_clk     (user_clk),
    .user_reset   (user_reset),
    .link_up      (link_up),
    .rq_beat      (rq_beat),
    .rq_valid     (rq_valid),
    .rq_ready     (rq_ready),
    .rc_beat      (rc_beat),
    .rc_valid     (rc_valid),
    .rc_ready     (rc_ready),
    .submit       (submit),
    .reap         (reap),
    .config_done  (config_done),
    .config_error (config_error)
  );

  // --------------------
  // Helpers
  // --------------------
  function automatic logic [7:0] take_bits(input int n);
    logic [7:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r    = {r[6:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_MASK) : (lfsr >> 1);
    end
    return r;
  endfunction

  // Expected request beat from the descriptor rules
  function automatic rq_beat_t expected_beat(input logic is_cfg, input addr_t addr,
                                             input tag_t tag, input logic payload,
                                             input dword_t value);
    rq_beat_t e;
    e = '0;
    e.user[3:0] = 4'hF;
    if (payload) begin
      e.data[31:0] = value;
      e.keep       = 4'b0001;
      e.last       = 1'b1;
    end else begin
      e.data[63:2]   = addr[63:2];
      e.data[74:64]  = 11'd1;
      e.data[78:75]  = is_cfg ? 4'd10 : 4'd1;
      e.data[95:80]  = 16'h0000;
      e.data[103:96] = tag;
      if (is_cfg) begin
        e.data[119:104] = 16'h0100;  // Bus 1, device 0
        e.data[120]     = 1'b1;
      end
      e.keep = 4'hF;
    end
    return e;
  endfunction

  function automatic rc_beat_t make_cpl(input tag_t tag, input logic [2:0] status);
    rc_beat_t b;
    b               = '0;
    b.data[30]      = 1'b1;
    b.data[45:43]   = status;
    b.data[71:64]   = tag;
    b.keep          = 4'b0111;
    b.last          = 1'b1;
    return b;
  endfunction

  task automatic check_beat(input string name, input rq_beat_t got, input rq_beat_t exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_dword(input string name, input dword_t got, input dword_t exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic report(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  // --------------------
  // Core model
  // --------------------
  initial begin
    rq_ready  = 1'b0;
    rc_valid  = 1'b0;
    rc_beat   = '0;
    cpl_delay = 0;
    cpl_idx   = 0;
    forever begin
      @(posedge user_clk);
      #2;
      if (user_reset) begin
        rq_ready  = 1'b0;
        rc_valid  = 1'b0;
        cpl_delay = 0;
        cpl_idx   = 0;
        cpl_tags.delete();
      end else begin
        rq_ready = (take_bits(2) != 8'd0);  // About 3 in 4
        if (rc_valid && rc_taken) begin
          rc_valid = 1'b0;
        end
        if (!rc_valid && cpl_tags.size() > 0) begin
          if (cpl_delay == 0) begin
            cpl_delay = int'(take_bits(3)) + 1;
          end else begin
            cpl_delay--;
            if (cpl_delay == 0) begin
              rc_beat  = make_cpl(cpl_tags.pop_front(),
                                  (cpl_idx == bad_cpl_idx) ? 3'd1 : 3'd0);
              rc_valid = 1'b1;
              cpl_idx++;
            end
          end
        end
      end
    end
  end

  // --------------------
  // Compare process
  // --------------------
  always @(posedge user_clk) begin
    addr_t  addr;
    addr_t  exp_addr;
    dword_t value;
    int     q;
    int     adv;
    if (user_reset) begin
      rc_taken    = 1'b0;
      outstanding = 1'b0;
      stalled     = 1'b0;
      beat_idx    = 0;
      cfg_req_cnt = 0;
    end else begin
      if (stalled) begin
        if (!rq_valid) begin
          report("rq_valid dropped while the beat was stalled");
        end else begin
          check_beat("rq_beat", rq_beat, stall_beat);
        end
      end
      stalled    = rq_valid && !rq_ready;
      stall_beat = rq_beat;

      if (outstanding && rq_valid) begin
        report("request beat sent while a completion is outstanding");
      end
      check_flag("rc_ready", rc_ready, outstanding);  // Only while a completion is due
      rc_taken = rc_valid && rc_ready;
      if (rc_taken) begin
        outstanding = 1'b0;
      end

      if (rq_valid && rq_ready) begin
        if (beat_idx == 0) begin
          if (rq_beat.last) begin
            report("first beat of a request carries last");
          end
          desc_hold = rq_beat;
          beat_idx  = 1;
        end else begin
          beat_idx = 0;
          req_total++;
          if (!rq_beat.last) begin
            report("second beat of a request lacks last");
          end
          if (desc_hold.data[78:75] == 4'd10) begin
            case (cfg_req_cnt)
              0: begin
                addr  = 64'(10'd4) << 2;
                value = BAR0[31:0];
              end
              1: begin
                addr  = 64'(10'd5) << 2;
                value = BAR0[63:32];
              end
              default: begin
                addr  = 64'(10'd1) << 2;
                value = 32'h0000_0006;
              end
            endcase
            if (cfg_req_cnt > 2) begin
              report("more than three config writes");
            end
            check_beat("cfg desc", desc_hold,
                       expected_beat(1'b1, addr, tag_t'(cfg_req_cnt), 1'b0, '0));
            check_beat("cfg data", rq_beat, expected_beat(1'b1, '0, '0, 1'b1, value));
            cpl_tags.push_back(tag_t'(cfg_req_cnt));
            outstanding = 1'b1;
            cfg_req_cnt++;
          end else begin
            addr  = {desc_hold.data[63:2], 2'b00};
            value = rq_beat.data[31:0];
            q     = (addr == BAR0 + 64'h1004) ? 1 : 0;
            if (addr != BAR0 + 64'h1000 && addr != BAR0 + 64'h1004) begin
              report($sformatf("doorbell write to unknown address %h", addr));
            end
            if (value >= dword_t'(DEPTH)) begin
              report($sformatf("doorbell %0d value %h is outside the queue", q, value));
            end
            exp_addr = BAR0 + ((q == 1) ? 64'h1004 : 64'h1000);
            check_beat("db desc", desc_hold, expected_beat(1'b0, exp_addr, '0, 1'b0, '0));
            check_beat("db data", rq_beat, expected_beat(1'b0, '0, '0, 1'b1, value));
            adv = int'((value - dword_t'(sent_cnt[q] % DEPTH)) % DEPTH);
            if (adv == 0 || sent_cnt[q] + adv > strobe_cnt[q]) begin
              report($sformatf("doorbell %0d stepped backward or ahead to %h", q, value));
            end
            sent_cnt[q] = sent_cnt[q] + adv;
            last_val[q] = value;
          end
        end
      end
    end
  end

  // --------------------
  // Stimulus
  // --------------------
  initial begin
    int          n;
    int          strobes;
    logic [7:0]  bits;
    link_up     = 1'b0;
    submit      = 1'b0;
    reap        = 1'b0;
    reset_req   = 1'b0;
    lfsr        = LFSR_SEED;
    errors      = 0;
    bad_cpl_idx = -1;
    req_total   = 0;
    sent_cnt    = '{0, 0};
    strobe_cnt  = '{0, 0};
    last_val    = '{32'd0, 32'd0};

    n = 0;
    while (user_reset !== 1'b0 && n < 20) begin
      @(posedge user_clk);
      n++;
    end
    if (user_reset !== 1'b0) report("reset never released");

    // Idle before link up, strobes ignored
    for (int i = 0; i < 20; i++) begin
      @(posedge user_clk);
      check_flag("rq_valid", rq_valid, 1'b0);
      check_flag("rc_ready", rc_ready, 1'b0);
      check_flag("config_done", config_done, 1'b0);
      check_flag("config_error", config_error, 1'b0);
      #4;
      submit = i[0];
    end
    @(posedge user_clk);
    #4;
    submit = 1'b0;
    if (req_total != 0) report("request seen before link up");

    link_up = 1'b1;
    n = 0;
    while (!config_done && !config_error && n < 2000) begin
      @(posedge user_clk);
      n++;
    end
    if (n >= 2000) report("timeout waiting for config_done");
    check_flag("config_done", config_done, 1'b1);
    check_flag("config_error", config_error, 1'b0);
    if (cfg_req_cnt != 3) report("config write count is not three");

    // Random submit and reap mix
    strobes = 0;
    n = 0;
    while (strobes < 40 && n < 400) begin
      @(posedge user_clk);
      #4;
      bits   = take_bits(2);
      submit = bits[0];
      reap   = bits[1];
      strobe_cnt[0] += int'(bits[0]);
      strobe_cnt[1] += int'(bits[1]);
      strobes += int'(bits[0]) + int'(bits[1]);
      n++;
    end
    @(posedge user_clk);
    #4;
    submit = 1'b0;
    reap   = 1'b0;

    n = 0;
    while ((sent_cnt[0] != strobe_cnt[0] || sent_cnt[1] != strobe_cnt[1] || rq_valid)
           && n < 1000) begin
      @(posedge user_clk);
      n++;
    end
    if (n >= 1000) report("timeout waiting for doorbell traffic to drain");
    check_dword("sq doorbell", last_val[0], dword_t'(strobe_cnt[0] % DEPTH));
    check_dword("cq doorbell", last_val[1], dword_t'(strobe_cnt[1] % DEPTH));

    // Second run with a bad second completion
    bad_cpl_idx = 1;
    #4;
    reset_req   = 1'b1;
    @(posedge user_clk);
    #4;
    reset_req = 1'b0;
    n = 0;
    while ((user_reset !== 1'b0 || !config_error) && n < 2000) begin
      @(posedge user_clk);
      n++;
    end
    if (n >= 2000) report("timeout waiting for config_error");
    check_flag("config_error", config_error, 1'b1);
    check_flag("config_done", config_done, 1'b0);
    for (int i = 0; i < 50; i++) begin
      @(posedge user_clk);
      check_flag("rq_valid", rq_valid, 1'b0);
      check_flag("config_done", config_done, 1'b0);
    end
    if (cfg_req_cnt != 2) report("config writes after the bad completion");

    $display("errors: %0d, requests seen: %0d", errors, req_total);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD = 20
) (
  input  logic reset_req,   // Asks for another reset
  output logic user_clk,
  output logic user_reset
);

  int rst_cnt = 2;  // Cycles of reset left

  initial begin
    user_clk = 1'b0;
    forever #(PERIOD / 2) user_clk = ~user_clk;
  end

  always @(posedge user_clk) begin
    if (reset_req) begin
      rst_cnt <= 2;
    end else if (rst_cnt > 0) begin
      rst_cnt <= rst_cnt - 1;
    end
  end

  assign user_reset = (rst_cnt != 0);

endmodule

`default_nettype wire

//--- nvme_host_port.f
src/nvme_host_pkg.sv
src/rq_arbiter.sv
src/host_controller.sv
src/config_sequencer.sv
src/doorbell_writer.sv
src/nvme_host_port.sv
dv/tb_clock_gen.sv
dv/nvme_host_port_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module nvme_host_port_tb \
  -f nvme_host_port.f \
  -o nvme_host_port_sim

out=$(./obj_dir/nvme_host_port_sim)
echo "$out"

# Pass only if the testbench printed its pass line
echo "$out" | grep -q "^Regression passed$"

//--- src/config_sequencer.sv
`default_nettype none

module config_sequencer #(
  parameter nvme_host_pkg::addr_t BAR0_BASE = 64'h0000_0010_0000_0000
) (
  input  logic                    user_clk,
  input  logic                    user_reset,

  input  logic                    start_config,
  output logic                    cfg_done,
  output logic                    cfg_error,

  output nvme_host_pkg::rq_beat_t rq_beat,
  output logic                    rq_valid,
  input  logic                    rq_ready,

  input  nvme_host_pkg::rc_beat_t rc_beat,
  input  logic                    rc_valid,
  output logic                    rc_ready
);
  import nvme_host_pkg::*;

  localparam reg_num_t   BAR0_LO_REG = 10'd4;
  localparam reg_num_t   BAR0_HI_REG = 10'd5;
  localparam logic [1:0] ROM_LAST    = 2'd2;

  cfg_state_t  state;
  logic [1:0]  rom_idx;
  tag_t        tag;      // Tag of the outstanding write
  reg_num_t    rom_reg;
  dword_t      rom_data;
  addr_t       cfg_addr;

  err_code_t   rc_err_code;
  cpl_status_t rc_status;
  tag_t        rc_tag;
  logic        cpl_good;

  // --------------------
  // Write ROM
  // --------------------
  always_comb begin
    rom_reg  = CMD_REG_NUM;
    rom_data = dword_t'(CMD_MEM_BUS_MASTER);
    case (rom_idx)
      2'd0: begin
        rom_reg  = BAR0_LO_REG;
        rom_data = BAR0_BASE[31:0];
      end
      2'd1: begin
        rom_reg  = BAR0_HI_REG;
        rom_data = BAR0_BASE[63:32];
      end
      default: ;
    endcase
  end

  // Register number sits in address bits 11:2
  assign cfg_addr = addr_t'({rom_reg, 2'b00});

  assign rq_valid = (state == SEND_DESC) || (state == SEND_DATA);
  assign rq_beat  = (state == SEND_DATA) ? data_beat(rom_data)
                                         : desc_beat(cfg_addr, CFG_WR0, tag, DEVICE_ID, 1'b1);

  // --------------------
  // Completion check
  // --------------------
  assign rc_err_code = rc_beat.data[15:12];
  assign rc_status   = rc_beat.data[45:43];
  assign rc_tag      = rc_beat.data[71:64];
  assign cpl_good    = (rc_err_code == '0) && (rc_status == '0) && (rc_tag == tag);

  assign rc_ready  = (state == WAIT_CPL);
  assign cfg_done  = (state == DONE);
  assign cfg_error = (state == FAIL);

  always_ff @(posedge user_clk) begin
    if (user_reset) begin
      state   <= IDLE;
      rom_idx <= '0;
      tag     <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (start_config) begin
            state   <= SEND_DESC;
            rom_idx <= '0;
            tag     <= '0;
          end
        end
        SEND_DESC: begin
          if (rq_ready) begin
            state <= SEND_DATA;
          end
        end
        SEND_DATA: begin
          if (rq_ready) begin
            state <= WAIT_CPL;
          end
        end
        WAIT_CPL: begin
          if (rc_valid) begin
            if (!cpl_good) begin
              state <= FAIL;
            end else if (rom_idx == ROM_LAST) begin
              state <= DONE;
            end else begin
              state   <= SEND_DESC;  // Next write after this completion
              rom_idx <= rom_idx + 2'd1;
              tag     <= tag + tag_t'(1);
            end
          end
        end
        default: ;  // DONE and FAIL hold until reset
      endcase
    end
  end

  // After the last beat the RQ side stays quiet while the completion is awaited
  assert property (@(posedge user_clk) disable iff (user_reset)
    rq_valid && rq_ready && rq_beat.last |=> state == WAIT_CPL && !rq_valid);

endmodule

`default_nettype wire

//--- src/doorbell_writer.sv
`default_nettype none

module doorbell_writer #(
  parameter nvme_host_pkg::addr_t BAR0_BASE = 64'h0000_0010_0000_0000
) (
  input  logic                    user_clk,
  input  logic                    user_reset,

  input  nvme_host_pkg::qidx_t    sq_tail,
  input  nvme_host_pkg::qidx_t    cq_head,
  input  logic [1:0]              db_update,  // [0] SQ, [1] CQ

  output nvme_host_pkg::rq_beat_t rq_beat,
  output logic                    rq_valid,
  input  logic                    rq_ready
);
  import nvme_host_pkg::*;

  db_state_t  state;
  logic [1:0] pending;    // Coalesced updates per queue
  logic [1:0] start_clr;
  logic       start;
  logic       pick_cq;
  logic       cq_sel;     // Queue of the write in flight
  qidx_t      db_value;
  addr_t      db_addr;

  // --------------------
  // Pending and pick
  // --------------------
  assign pick_cq   = !pending[0];  // SQ goes first
  assign start     = (state == DB_IDLE) && (pending != 2'b00);
  assign start_clr = start ? (pick_cq ? 2'b10 : 2'b01) : 2'b00;

  always_ff @(posedge user_clk) begin
    if (user_reset) begin
      pending <= '0;
    end else begin
      // Pointer captured now already holds any update of this cycle
      pending <= (pending | db_update) & ~start_clr;
    end
  end

  always_ff @(posedge user_clk) begin
    if (start) begin
      cq_sel   <= pick_cq;
      db_value <= pick_cq ? cq_head : sq_tail;
    end
  end

  // --------------------
  // Request
  // --------------------
  assign db_addr  = BAR0_BASE + (cq_sel ? CQ_HEAD_DB_OFFSET : SQ_TAIL_DB_OFFSET);
  assign rq_valid = (state != DB_IDLE);
  assign rq_beat  = (state == DB_DATA) ? data_beat(dword_t'(db_value))
                                       : desc_beat(db_addr, MEM_WR, tag_t'(0),
                                                   pcie_id_t'(0), 1'b0);

  always_ff @(posedge user_clk) begin
    if (user_reset) begin
      state <= DB_IDLE;
    end else begin
      case (state)
        DB_IDLE: begin
          if (start) begin
            state <= DB_DESC;
          end
        end
        DB_DESC: begin
          if (rq_ready) begin
            state <= DB_DATA;
          end
        end
        DB_DATA: begin
          if (rq_ready) begin
            state <= DB_IDLE;  // Pending may start the next one
          end
        end
        default: state <= DB_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/host_controller.sv
`default_nettype none

module host_controller #(
  parameter int QUEUE_DEPTH = 16
) (
  input  logic                 user_clk,
  input  logic                 user_reset,

  input  logic                 link_up,
  output logic                 start_config,
  input  logic                 cfg_done,

  input  logic                 submit,
  input  logic                 reap,
  output nvme_host_pkg::qidx_t sq_tail,
  output nvme_host_pkg::qidx_t cq_head,
  output logic [1:0]           db_update   // [0] SQ, [1] CQ
);
  import nvme_host_pkg::*;

  ctl_state_t state;
  logic       q_en;      // Queue strobes accepted
  logic       started;   // Enumeration already kicked off

  // Advance a pointer, wrapping at the queue depth
  function automatic qidx_t step(input qidx_t ptr);
    return (ptr == qidx_t'(QUEUE_DEPTH - 1)) ? qidx_t'(0) : ptr + qidx_t'(1);
  endfunction

  assign q_en = cfg_done && (state != WAIT_LINK);

  // --------------------
  // Link and enumeration
  // --------------------
  always_ff @(posedge user_clk) begin
    if (user_reset) begin
      state        <= WAIT_LINK;
      start_config <= 1'b0;
    end else begin
      start_config <= 1'b0;
      case (state)
        WAIT_LINK: begin
          if (link_up) begin
            state        <= CONFIG;
            start_config <= 1'b1;
          end
        end
        CONFIG: begin
          if (cfg_done) begin
            state <= RUN;
          end
        end
        default: ;  // RUN until reset
      endcase
    end
  end

  // --------------------
  // Queue pointers
  // --------------------
  always_ff @(posedge user_clk) begin
    if (user_reset) begin
      sq_tail   <= '0;
      cq_head   <= '0;
      db_update <= '0;
    end else begin
      db_update <= {reap && q_en, submit && q_en};  // Same cycle as the new pointer
      if (submit && q_en) begin
        sq_tail <= step(sq_tail);
      end
      if (reap && q_en) begin
        cq_head <= step(cq_head);
      end
    end
  end

  always_ff @(posedge user_clk) begin
    if (user_reset) begin
      started <= 1'b0;
    end else if (start_config) begin
      started <= 1'b1;
    end
  end

  // Only one enumeration per reset
  assert property (@(posedge user_clk) disable iff (user_reset)
    start_config |-> !started);

endmodule

`default_nettype wire

//--- src/nvme_host_pkg.sv
`default_nettype none

package nvme_host_pkg;

  // --------------------
  // Stream widths
  // --------------------
  localparam int C_DATA_WIDTH  = 128;
  localparam int KEEP_WIDTH    = C_DATA_WIDTH / 32;  // One bit per dword
  localparam int RQ_USER_WIDTH = 62;
  localparam int RC_USER_WIDTH = 75;

  typedef logic [C_DATA_WIDTH-1:0]  data_t;
  typedef logic [KEEP_WIDTH-1:0]    keep_t;
  typedef logic [RQ_USER_WIDTH-1:0] rq_user_t;
  typedef logic [RC_USER_WIDTH-1:0] rc_user_t;

  typedef struct packed {
    data_t    data;
    keep_t    keep;
    rq_user_t user;
    logic     last;
  } rq_beat_t;

  typedef struct packed {
    data_t    data;
    keep_t    keep;
    rc_user_t user;
    logic     last;
  } rc_beat_t;

  // --------------------
  // Descriptor fields
  // --------------------
  typedef logic [7:0]  tag_t;
  typedef logic [10:0] dword_count_t;
  typedef logic [2:0]  cpl_status_t;
  typedef logic [3:0]  err_code_t;
  typedef logic [63:0] addr_t;
  typedef logic [9:0]  reg_num_t;
  typedef logic [31:0] dword_t;
  typedef logic [15:0] pcie_id_t;  // Bus/device/function
  typedef logic [15:0] qidx_t;     // Queue pointer as written to a doorbell

  typedef enum logic [3:0] {
    MEM_WR  = 4'd1,
    CFG_WR0 = 4'd10
  } req_type_t;

  localparam pcie_id_t REQUESTER_ID = 16'h0000;  // Root port
  localparam pcie_id_t DEVICE_ID    = 16'h0100;  // Bus 1, device 0, function 0

  localparam reg_num_t    CMD_REG_NUM        = 10'd1;
  localparam logic [15:0] CMD_MEM_BUS_MASTER = 16'h0006;  // Memory space and bus master

  // Doorbell stride 0
  localparam addr_t SQ_TAIL_DB_OFFSET = 64'h1000;
  localparam addr_t CQ_HEAD_DB_OFFSET = 64'h1004;

  localparam logic [3:0] FIRST_BE = 4'hF;

  // --------------------
  // State machines
  // --------------------
  typedef enum logic [1:0] {
    WAIT_LINK,
    CONFIG,
    RUN
  } ctl_state_t;

  typedef enum logic [2:0] {
    IDLE,
    SEND_DESC,
    SEND_DATA,
    WAIT_CPL,
    DONE,
    FAIL
  } cfg_state_t;

  typedef enum logic [1:0] {
    DB_IDLE,
    DB_DESC,
    DB_DATA
  } db_state_t;

  // Descriptor beat of a single-dword request
  function automatic rq_beat_t desc_beat(input addr_t addr, input req_type_t req_type,
                                         input tag_t tag, input pcie_id_t cpl_id,
                                         input logic cpl_id_en);
    rq_beat_t beat;
    beat               = '0;
    beat.data[63:2]    = addr[63:2];
    beat.data[74:64]   = dword_count_t'(1);
    beat.data[78:75]   = req_type;
    beat.data[95:80]   = REQUESTER_ID;
    beat.data[103:96]  = tag;
    beat.data[119:104] = cpl_id;
    beat.data[120]     = cpl_id_en;  // Completer ID enable
    beat.keep          = '1;
    beat.user[3:0]     = FIRST_BE;
    return beat;
  endfunction

  // Payload beat, one dword in the low lane
  function automatic rq_beat_t data_beat(input dword_t value);
    rq_beat_t beat;
    beat            = '0;
    beat.data[31:0] = value;
    beat.keep       = keep_t'(1);
    beat.user[3:0]  = FIRST_BE;
    beat.last       = 1'b1;
    return beat;
  endfunction

endpackage

`default_nettype wire

//--- src/nvme_host_port.sv
`default_nettype none

module nvme_host_port #(
  parameter int                   QUEUE_DEPTH = 16,
  parameter nvme_host_pkg::addr_t BAR0_BASE   = 64'h0000_0010_0000_0000
) (
  input  logic                    user_clk,
  input  logic                    user_reset,
  input  logic                    link_up,

  // Requester request to the core
  output nvme_host_pkg::rq_beat_t rq_beat,
  output logic                    rq_valid,
  input  logic                    rq_ready,

  // Requester completion from the core
  input  nvme_host_pkg::rc_beat_t rc_beat,
  input  logic                    rc_valid,
  output logic                    rc_ready,

  input  logic                    submit,
  input  logic                    reap,
  output logic                    config_done,
  output logic                    config_error
);
  import nvme_host_pkg::*;

  logic       start_config;
  qidx_t      sq_tail;
  qidx_t      cq_head;
  logic [1:0] db_update;

  // --------------------
  // Source to arbiter
  // --------------------
  rq_beat_t cfg_rq_beat;
  logic     cfg_rq_valid;
  logic     cfg_rq_ready;
  rq_beat_t db_rq_beat;
  logic     db_rq_valid;
  logic     db_rq_ready;

  host_controller #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) i_host_controller (
    .user_clk     (user_clk),
    .user_reset   (user_reset),
    .link_up      (link_up),
    .start_config (start_config),
    .cfg_done     (config_done),
    .submit       (submit),
    .reap         (reap),
    .sq_tail      (sq_tail),
    .cq_head      (cq_head),
    .db_update    (db_update)
  );

  config_sequencer #(
    .BAR0_BASE (BAR0_BASE)
  ) i_config_sequencer (
    .user_clk     (user_clk),
    .user_reset   (user_reset),
    .start_config (start_config),
    .cfg_done     (config_done),
    .cfg_error    (config_error),
    .rq_beat      (cfg_rq_beat),
    .rq_valid     (cfg_rq_valid),
    .rq_ready     (cfg_rq_ready),
    .rc_beat      (rc_beat),
    .rc_valid     (rc_valid),
    .rc_ready     (rc_ready)
  );

  doorbell_writer #(
    .BAR0_BASE (BAR0_BASE)
  ) i_doorbell_writer (
    .user_clk   (user_clk),
    .user_reset (user_reset),
    .sq_tail    (sq_tail),
    .cq_head    (cq_head),
    .db_update  (db_update),
    .rq_beat    (db_rq_beat),
    .rq_valid   (db_rq_valid),
    .rq_ready   (db_rq_ready)
  );

  rq_arbiter i_rq_arbiter (
    .user_clk   (user_clk),
    .user_reset (user_reset),
    .cfg_beat   (cfg_rq_beat),
    .cfg_valid  (cfg_rq_valid),
    .cfg_ready  (cfg_rq_ready),
    .db_beat    (db_rq_beat),
    .db_valid   (db_rq_valid),
    .db_ready   (db_rq_ready),
    .rq_beat    (rq_beat),
    .rq_valid   (rq_valid),
    .rq_ready   (rq_ready)
  );

endmodule

`default_nettype wire

//--- src/rq_arbiter.sv
`default_nettype none

module rq_arbiter (
  input  logic                    user_clk,
  input  logic                    user_reset,

  input  nvme_host_pkg::rq_beat_t cfg_beat,
  input  logic                    cfg_valid,
  output logic                    cfg_ready,

  input  nvme_host_pkg::rq_beat_t db_beat,
  input  logic                    db_valid,
  output logic                    db_ready,

  output nvme_host_pkg::rq_beat_t rq_beat,
  output logic                    rq_valid,
  input  logic                    rq_ready
);
  import nvme_host_pkg::*;

  logic locked;   // Grant held until last beat
  logic gnt_db;   // 1 selects doorbell writer
  logic sel_db;
  logic req_end;

  // Configurator wins when free
  assign sel_db = locked ? gnt_db : !cfg_valid;

  assign rq_beat   = sel_db ? db_beat : cfg_beat;
  assign rq_valid  = sel_db ? db_valid : cfg_valid;
  assign cfg_ready = rq_ready && !sel_db;
  assign db_ready  = rq_ready && sel_db;
  assign req_end   = rq_valid && rq_ready && rq_beat.last;

  always_ff @(posedge user_clk) begin
    if (user_reset) begin
      locked <= 1'b0;
      gnt_db <= 1'b0;
    end else if (!locked) begin
      if (rq_valid && !req_end) begin  // Lock on a stalled or first beat
        locked <= 1'b1;
        gnt_db <= sel_db;
      end
    end else if (req_end) begin
      locked <= 1'b0;
    end
  end

  // Source must not switch under back-pressure
  assert property (@(posedge user_clk) disable iff (user_reset)
    rq_valid && !rq_ready |=> sel_db == $past(sel_db));

endmodule

`default_nettype wire
